// File: hdl/slink_ctrl_params.svh
`ifndef SLINK_CTRL_PARAMS_SVH
`define SLINK_CTRL_PARAMS_SVH

// Bus and field widths
`define SLINK_ADDR_W            9
`define SLINK_DATA_W            32
`define SLINK_REGION_BIT        8
`define SLINK_STATUS_W          6
`define SLINK_US_W              10

// Control region offsets
`define SLINK_REG_CTRL          8'h00
`define SLINK_REG_INT_EN        8'h04
`define SLINK_REG_STATUS        8'h08
`define SLINK_REG_PX_CTRL       8'h0C
`define SLINK_REG_TIMING        8'h10
`define SLINK_REG_LINK_STATE    8'h14

// CTRL, PX_CTRL and TIMING fields
`define SLINK_CTRL_ENABLE       0
`define SLINK_CTRL_CRC_RESET    1
`define SLINK_PX_CTRL_RESET     3
`define SLINK_PX_CTRL_WAKE      4
`define SLINK_TIMING_HR_LSB     16

// STATUS and INT_EN bits
`define SLINK_ST_ECC_CORRECTED  0
`define SLINK_ST_ECC_CORRUPTED  1
`define SLINK_ST_CRC_CORRUPTED  2
`define SLINK_ST_RESET_SEEN     3
`define SLINK_ST_WAKE_SEEN      4
`define SLINK_ST_IN_PSTATE      5

// Reset defaults and P-state timing
`define SLINK_PX_ENTER_CYCLES   8
`define SLINK_PX_EXIT_CYCLES    16
`define SLINK_COUNT_1US_RST     10'd10
`define SLINK_HARD_RESET_US_RST 10'd2

`endif

// File: hdl/slink_apb_pkg.sv
`include "slink_ctrl_params.svh"

package slink_apb_pkg;

  // Byte offset inside one 256-byte region
  typedef logic [7:0] reg_addr_t;

  typedef logic [`SLINK_DATA_W-1:0] reg_data_t;

  // One bit per link event, same layout in STATUS and INT_EN
  typedef logic [`SLINK_STATUS_W-1:0] status_t;

endpackage

// File: hdl/slink_link_pkg.sv
`include "slink_ctrl_params.svh"

package slink_link_pkg;

  // Encoding is visible in LINK_STATE bits 1:0
  typedef enum logic [1:0] {
    P0       = 2'd0,
    PX_ENTER = 2'd1,
    PX       = 2'd2,
    PX_WAKE  = 2'd3
  } px_state_e;

  // 0 means no request pending
  typedef logic [1:0] px_level_t;

  // Cycles per microsecond, or microseconds of hard reset
  typedef logic [`SLINK_US_W-1:0] us_count_t;

endpackage

// File: hdl/slink_sideband_sync.sv
`timescale 1ns/1ns

module slink_sideband_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic apb_clk,
  input  logic arst_n,
  input  logic gpio_reset_n,
  input  logic gpio_wake_n,
  output logic reset_seen,
  output logic wake_seen
);

  // Bit 0 is the reset pin, bit 1 the wake pin
  logic [SYNC_STAGES-1:0][1:0] sync_q;
  logic [1:0]                  last_q;
  logic [1:0]                  fell;

  assign fell = last_q & ~sync_q[SYNC_STAGES-1];

  always_ff @(posedge apb_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q     <= '1;
      last_q     <= 2'b11;
      reset_seen <= 1'b0;
      wake_seen  <= 1'b0;
    end else begin
      sync_q[0] <= {gpio_wake_n, gpio_reset_n};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      last_q     <= sync_q[SYNC_STAGES-1];
      reset_seen <= fell[0];
      wake_seen  <= fell[1];
    end
  end

endmodule

// File: hdl/slink_px_fsm.sv
`timescale 1ns/1ns
`include "slink_ctrl_params.svh"

module slink_px_fsm (
  input  logic                      apb_clk,
  input  logic                      arst_n,
  input  logic                      enable,
  input  logic                      p1_req,
  input  logic                      p2_req,
  input  logic                      p3_req,
  input  logic [2:0]                sw_px_enter,
  input  logic                      tx_sop,
  input  logic                      wake_seen,
  input  logic                      sw_link_wake,
  input  logic                      in_reset_state,
  output slink_link_pkg::px_state_e px_state,
  output slink_link_pkg::px_level_t px_level,
  output logic                      px_entered,
  output logic                      in_px_state,
  output logic                      gpio_wake_n_oen
);

  localparam int MAX_CYCLES = (`SLINK_PX_ENTER_CYCLES > `SLINK_PX_EXIT_CYCLES) ?
                              `SLINK_PX_ENTER_CYCLES : `SLINK_PX_EXIT_CYCLES;
  localparam int CNT_W      = $clog2(MAX_CYCLES);

  slink_link_pkg::px_level_t req_level;
  logic [CNT_W-1:0]          cnt;

  // Highest level wins
  always_comb begin
    if (p3_req || sw_px_enter[2]) begin
      req_level = 2'd3;
    end else if (p2_req || sw_px_enter[1]) begin
      req_level = 2'd2;
    end else if (p1_req || sw_px_enter[0]) begin
      req_level = 2'd1;
    end else begin
      req_level = 2'd0;
    end
  end

  always_ff @(posedge apb_clk or negedge arst_n) begin
    if (!arst_n) begin
      px_state   <= slink_link_pkg::P0;
      px_level   <= 2'd0;
      cnt        <= '0;
      px_entered <= 1'b0;
    end else if (in_reset_state) begin
      px_state   <= slink_link_pkg::P0;
      px_level   <= 2'd0;
      cnt        <= '0;
      px_entered <= 1'b0;
    end else begin
      px_entered <= 1'b0;
      case (px_state)
        slink_link_pkg::P0: begin
          if (enable && req_level != 2'd0) begin
            px_state <= slink_link_pkg::PX_ENTER;
            px_level <= req_level;
            cnt      <= CNT_W'(`SLINK_PX_ENTER_CYCLES - 1);
          end
        end
        slink_link_pkg::PX_ENTER: begin
          if (cnt == '0) begin
            px_state   <= slink_link_pkg::PX;
            px_entered <= 1'b1;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        slink_link_pkg::PX: begin
          if (tx_sop || wake_seen || sw_link_wake) begin
            px_state <= slink_link_pkg::PX_WAKE;
            cnt      <= CNT_W'(`SLINK_PX_EXIT_CYCLES - 1);
          end
        end
        default: begin
          // Exit sequence, wake pin driven throughout
          if (cnt == '0) begin
            px_state <= slink_link_pkg::P0;
            px_level <= 2'd0;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
      endcase
    end
  end

  assign in_px_state     = (px_state == slink_link_pkg::PX);
  assign gpio_wake_n_oen = (px_state == slink_link_pkg::PX_WAKE);

endmodule

// File: hdl/slink_reset_timer.sv
`timescale 1ns/1ns

module slink_reset_timer (
  input  logic                      apb_clk,
  input  logic                      arst_n,
  input  logic                      sw_link_reset,
  input  logic                      reset_seen,
  input  logic                      crc_corrupted,
  input  logic                      crc_causes_reset,
  input  slink_link_pkg::us_count_t count_1us,
  input  slink_link_pkg::us_count_t hard_reset_us,
  output logic                      in_reset_state,
  output logic                      gpio_reset_n_oen
);

  slink_link_pkg::us_count_t pre_cnt;
  slink_link_pkg::us_count_t us_cnt;
  logic                      reset_req;
  logic                      us_tick;

  assign reset_req = sw_link_reset | reset_seen | (crc_corrupted & crc_causes_reset);
  assign us_tick   = (pre_cnt == count_1us - 1'b1);

  always_ff @(posedge apb_clk or negedge arst_n) begin
    if (!arst_n) begin
      in_reset_state <= 1'b0;
      pre_cnt        <= '0;
      us_cnt         <= '0;
    end else if (!in_reset_state) begin
      if (reset_req) begin
        in_reset_state <= 1'b1;
        pre_cnt        <= '0;
        us_cnt         <= '0;
      end
    end else if (us_tick) begin
      // One microsecond done
      pre_cnt <= '0;
      if (us_cnt == hard_reset_us - 1'b1) begin
        in_reset_state <= 1'b0;
      end else begin
        us_cnt <= us_cnt + 1'b1;
      end
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // Pin is driven low for the whole hard reset
  assign gpio_reset_n_oen = in_reset_state;

endmodule

// File: hdl/slink_apb_regs.sv
`timescale 1ns/1ns
`include "slink_ctrl_params.svh"

module slink_apb_regs (
  input  logic                      apb_clk,
  input  logic                      arst_n,
  input  logic [`SLINK_ADDR_W-1:0]  paddr,
  input  logic                      pwrite,
  input  logic                      psel,
  input  logic                      penable,
  input  slink_apb_pkg::reg_data_t  pwdata,
  output slink_apb_pkg::reg_data_t  prdata,
  output logic                      pready,
  output logic                      pslverr,

  input  logic                      ecc_corrected,
  input  logic                      ecc_corrupted,
  input  logic                      crc_corrupted,
  input  logic                      reset_seen,
  input  logic                      wake_seen,
  input  logic                      px_entered,
  input  slink_link_pkg::px_state_e px_state,
  input  slink_link_pkg::px_level_t px_level,
  input  logic                      in_reset_state,

  output logic                      interrupt,
  output logic                      enable,
  output logic                      crc_causes_reset,
  output slink_link_pkg::us_count_t count_1us,
  output slink_link_pkg::us_count_t hard_reset_us,
  output logic [2:0]                sw_px_enter,
  output logic                      sw_link_reset,
  output logic                      sw_link_wake
);

  slink_apb_pkg::reg_addr_t offset;
  slink_apb_pkg::reg_data_t rd_data;
  slink_apb_pkg::status_t   int_en;
  slink_apb_pkg::status_t   status;
  slink_apb_pkg::status_t   events;
  slink_apb_pkg::status_t   clr_mask;
  logic                     access;
  logic                     bist_sel;
  logic                     mapped;
  logic                     wr_en;
  logic                     px_wr;

  //----------------------------------------------------------
  // Decode and read mux
  //----------------------------------------------------------
  assign access   = psel & penable;
  assign bist_sel = paddr[`SLINK_REGION_BIT];
  assign offset   = paddr[7:0];
  assign pready   = access;

  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (offset)
      `SLINK_REG_CTRL: begin
        rd_data[`SLINK_CTRL_ENABLE]    = enable;
        rd_data[`SLINK_CTRL_CRC_RESET] = crc_causes_reset;
      end
      `SLINK_REG_INT_EN:  rd_data[`SLINK_STATUS_W-1:0] = int_en;
      `SLINK_REG_STATUS:  rd_data[`SLINK_STATUS_W-1:0] = status;
      // Write-only pulses
      `SLINK_REG_PX_CTRL: rd_data = '0;
      `SLINK_REG_TIMING: begin
        rd_data[`SLINK_US_W-1:0]                     = count_1us;
        rd_data[`SLINK_TIMING_HR_LSB +: `SLINK_US_W] = hard_reset_us;
      end
      `SLINK_REG_LINK_STATE: begin
        rd_data[1:0] = px_state;
        rd_data[3:2] = px_level;
        rd_data[4]   = in_reset_state;
      end
      default: mapped = 1'b0;
    endcase
  end

  // No BIST behind bit 8, so that whole region errors
  assign pslverr = access & (bist_sel | ~mapped);
  assign prdata  = (access & ~pslverr) ? rd_data : '0;
  assign wr_en   = access & pwrite & ~pslverr;
  assign px_wr   = wr_en & (offset == `SLINK_REG_PX_CTRL);

  //----------------------------------------------------------
  // Control registers
  //----------------------------------------------------------
  always_ff @(posedge apb_clk or negedge arst_n) begin
    if (!arst_n) begin
      enable           <= 1'b0;
      crc_causes_reset <= 1'b0;
      int_en           <= '0;
      count_1us        <= `SLINK_COUNT_1US_RST;
      hard_reset_us    <= `SLINK_HARD_RESET_US_RST;
    end else if (wr_en) begin
      case (offset)
        `SLINK_REG_CTRL: begin
          enable           <= pwdata[`SLINK_CTRL_ENABLE];
          crc_causes_reset <= pwdata[`SLINK_CTRL_CRC_RESET];
        end
        `SLINK_REG_INT_EN: int_en <= pwdata[`SLINK_STATUS_W-1:0];
        `SLINK_REG_TIMING: begin
          count_1us     <= pwdata[`SLINK_US_W-1:0];
          hard_reset_us <= pwdata[`SLINK_TIMING_HR_LSB +: `SLINK_US_W];
        end
        default: ;
      endcase
    end
  end

  //----------------------------------------------------------
  // W1C status and PX_CTRL pulses
  //----------------------------------------------------------
  always_comb begin
    events                          = '0;
    events[`SLINK_ST_ECC_CORRECTED] = ecc_corrected;
    events[`SLINK_ST_ECC_CORRUPTED] = ecc_corrupted;
    events[`SLINK_ST_CRC_CORRUPTED] = crc_corrupted;
    events[`SLINK_ST_RESET_SEEN]    = reset_seen;
    events[`SLINK_ST_WAKE_SEEN]     = wake_seen;
    events[`SLINK_ST_IN_PSTATE]     = px_entered;
  end

  assign clr_mask = (wr_en && offset == `SLINK_REG_STATUS) ?
                    pwdata[`SLINK_STATUS_W-1:0] : '0;

  always_ff @(posedge apb_clk or negedge arst_n) begin
    if (!arst_n) begin
      status        <= '0;
      sw_px_enter   <= 3'b000;
      sw_link_reset <= 1'b0;
      sw_link_wake  <= 1'b0;
    end else begin
      // New event beats a clear in the same cycle
      status        <= (status & ~clr_mask) | events;
      sw_px_enter   <= px_wr ? pwdata[2:0] : 3'b000;
      sw_link_reset <= px_wr & pwdata[`SLINK_PX_CTRL_RESET];
      sw_link_wake  <= px_wr & pwdata[`SLINK_PX_CTRL_WAKE];
    end
  end

  assign interrupt = |(status & int_en);

endmodule

// File: hdl/slink_ctrl_top.sv
`timescale 1ns/1ns
`include "slink_ctrl_params.svh"

module slink_ctrl_top (
  input  logic                     apb_clk,
  input  logic                     arst_n,
  input  logic [`SLINK_ADDR_W-1:0] apb_paddr,
  input  logic                     apb_pwrite,
  input  logic                     apb_psel,
  input  logic                     apb_penable,
  input  slink_apb_pkg::reg_data_t apb_pwdata,
  output slink_apb_pkg::reg_data_t apb_prdata,
  output logic                     apb_pready,
  output logic                     apb_pslverr,

  input  logic                     ecc_corrected,
  input  logic                     ecc_corrupted,
  input  logic                     crc_corrupted,
  input  logic                     tx_sop,
  input  logic                     p1_req,
  input  logic                     p2_req,
  input  logic                     p3_req,
  input  logic                     gpio_reset_n,
  input  logic                     gpio_wake_n,

  output logic                     interrupt,
  output logic                     in_px_state,
  output logic                     in_reset_state,
  output logic                     gpio_reset_n_oen,
  output logic                     gpio_wake_n_oen
);

  logic                      enable;
  logic                      crc_causes_reset;
  slink_link_pkg::us_count_t count_1us;
  slink_link_pkg::us_count_t hard_reset_us;
  logic [2:0]                sw_px_enter;
  logic                      sw_link_reset;
  logic                      sw_link_wake;
  logic                      reset_seen;
  logic                      wake_seen;
  slink_link_pkg::px_state_e px_state;
  slink_link_pkg::px_level_t px_level;
  logic                      px_entered;

  //----------------------------------------------------------
  // Register block
  //----------------------------------------------------------
  slink_apb_regs slink_apb_regs_inst (
    .apb_clk          ( apb_clk          ),
    .arst_n           ( arst_n           ),
    .paddr            ( apb_paddr        ),
    .pwrite           ( apb_pwrite       ),
    .psel             ( apb_psel         ),
    .penable          ( apb_penable      ),
    .pwdata           ( apb_pwdata       ),
    .prdata           ( apb_prdata       ),
    .pready           ( apb_pready       ),
    .pslverr          ( apb_pslverr      ),
    .ecc_corrected    ( ecc_corrected    ),
    .ecc_corrupted    ( ecc_corrupted    ),
    .crc_corrupted    ( crc_corrupted    ),
    .reset_seen       ( reset_seen       ),
    .wake_seen        ( wake_seen        ),
    .px_entered       ( px_entered       ),
    .px_state         ( px_state         ),
    .px_level         ( px_level         ),
    .in_reset_state   ( in_reset_state   ),
    .interrupt        ( interrupt        ),
    .enable           ( enable           ),
    .crc_causes_reset ( crc_causes_reset ),
    .count_1us        ( count_1us        ),
    .hard_reset_us    ( hard_reset_us    ),
    .sw_px_enter      ( sw_px_enter      ),
    .sw_link_reset    ( sw_link_reset    ),
    .sw_link_wake     ( sw_link_wake     )
  );

  //----------------------------------------------------------
  // Sideband pins, power states and hard reset
  //----------------------------------------------------------
  slink_sideband_sync #(
    .SYNC_STAGES ( 2 )
  ) slink_sideband_sync_inst (
    .apb_clk      ( apb_clk      ),
    .arst_n       ( arst_n       ),
    .gpio_reset_n ( gpio_reset_n ),
    .gpio_wake_n  ( gpio_wake_n  ),
    .reset_seen   ( reset_seen   ),
    .wake_seen    ( wake_seen    )
  );

  slink_px_fsm slink_px_fsm_inst (
    .apb_clk         ( apb_clk         ),
    .arst_n          ( arst_n          ),
    .enable          ( enable          ),
    .p1_req          ( p1_req          ),
    .p2_req          ( p2_req          ),
    .p3_req          ( p3_req          ),
    .sw_px_enter     ( sw_px_enter     ),
    .tx_sop          ( tx_sop          ),
    .wake_seen       ( wake_seen       ),
    .sw_link_wake    ( sw_link_wake    ),
    .in_reset_state  ( in_reset_state  ),
    .px_state        ( px_state        ),
    .px_level        ( px_level        ),
    .px_entered      ( px_entered      ),
    .in_px_state     ( in_px_state     ),
    .gpio_wake_n_oen ( gpio_wake_n_oen )
  );

  slink_reset_timer slink_reset_timer_inst (
    .apb_clk          ( apb_clk          ),
    .arst_n           ( arst_n           ),
    .sw_link_reset    ( sw_link_reset    ),
    .reset_seen       ( reset_seen       ),
    .crc_corrupted    ( crc_corrupted    ),
    .crc_causes_reset ( crc_causes_reset ),
    .count_1us        ( count_1us        ),
    .hard_reset_us    ( hard_reset_us    ),
    .in_reset_state   ( in_reset_state   ),
    .gpio_reset_n_oen ( gpio_reset_n_oen )
  );

endmodule

// File: sim/tb_slink_ctrl.sv
`timescale 1ns/1ns
`include "slink_ctrl_params.svh"

module tb_slink_ctrl;

  localparam int MAX_ROWS = 96;

  // Row operations
  localparam int OP_WR    = 0;
  localparam int OP_RD    = 1;
  localparam int OP_PULSE = 2;
  localparam int OP_PIN   = 3;
  localparam int OP_WAIT  = 4;
  localparam int OP_CHK   = 5;
  localparam int OP_MEAS  = 6;

  // Output selects
  localparam int OUT_INTERRUPT = 0;
  localparam int OUT_IN_PX     = 1;
  localparam int OUT_IN_RESET  = 2;
  localparam int OUT_RESET_OEN = 3;
  localparam int OUT_WAKE_OEN  = 4;
  localparam int OUT_PREADY    = 5;
  localparam int OUT_PSLVERR   = 6;

  // Pulse mask bits
  localparam int PL_ECC_CORR = 32'h01;
  localparam int PL_CRC      = 32'h04;
  localparam int PL_TX_SOP   = 32'h08;
  localparam int PL_P1       = 32'h10;
  localparam int PL_P2       = 32'h20;
  localparam int PL_P3       = 32'h40;

  localparam int PIN_RESET = 0;
  localparam int PIN_WAKE  = 1;

  logic                     apb_clk;
  logic                     arst_n;
  logic [`SLINK_ADDR_W-1:0] apb_paddr;
  logic                     apb_pwrite;
  logic                     apb_psel;
  logic                     apb_penable;
  slink_apb_pkg::reg_data_t apb_pwdata;
  slink_apb_pkg::reg_data_t apb_prdata;
  logic                     apb_pready;
  logic                     apb_pslverr;
  logic                     ecc_corrected;
  logic                     ecc_corrupted;
  logic                     crc_corrupted;
  logic                     tx_sop;
  logic                     p1_req;
  logic                     p2_req;
  logic                     p3_req;
  logic                     gpio_reset_n;
  logic                     gpio_wake_n;
  logic                     interrupt;
  logic                     in_px_state;
  logic                     in_reset_state;
  logic                     gpio_reset_n_oen;
  logic                     gpio_wake_n_oen;

  int          row_op   [MAX_ROWS];
  logic [31:0] row_addr [MAX_ROWS];
  logic [31:0] row_data [MAX_ROWS];
  logic [31:0] row_exp  [MAX_ROWS];
  int          row_test [MAX_ROWS];
  int          n_rows;
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          test_errors;
  int          limit;
  int          cycles;
  logic [31:0] r_ctrl;
  logic [31:0] r_int_en;
  logic [31:0] r_timing;

  slink_ctrl_top slink_ctrl_top_inst (
    .apb_clk          ( apb_clk          ),
    .arst_n           ( arst_n           ),
    .apb_paddr        ( apb_paddr        ),
    .apb_pwrite       ( apb_pwrite       ),
    .apb_psel         ( apb_psel         ),
    .apb_penable      ( apb_penable      ),
    .apb_pwdata       ( apb_pwdata       ),
    .apb_prdata       ( apb_prdata       ),
    .apb_pready       ( apb_pready       ),
    .apb_pslverr      ( apb_pslverr      ),
    .ecc_corrected    ( ecc_corrected    ),
    .ecc_corrupted    ( ecc_corrupted    ),
    .crc_corrupted    ( crc_corrupted    ),
    .tx_sop           ( tx_sop           ),
    .p1_req           ( p1_req           ),
    .p2_req           ( p2_req           ),
    .p3_req           ( p3_req           ),
    .gpio_reset_n     ( gpio_reset_n     ),
    .gpio_wake_n      ( gpio_wake_n      ),
    .interrupt        ( interrupt        ),
    .in_px_state      ( in_px_state      ),
    .in_reset_state   ( in_reset_state   ),
    .gpio_reset_n_oen ( gpio_reset_n_oen ),
    .gpio_wake_n_oen  ( gpio_wake_n_oen  )
  );

  initial begin
    apb_clk = 1'b0;
    forever #50 apb_clk = ~apb_clk;
  end

  //------------------------------------------------------------
  // Checking helpers
  //------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
      n_errors++;
      test_errors++;
    end
  endtask

  function automatic logic out_value(input int sel);
    case (sel)
      OUT_INTERRUPT: return interrupt;
      OUT_IN_PX:     return in_px_state;
      OUT_IN_RESET:  return in_reset_state;
      OUT_RESET_OEN: return gpio_reset_n_oen;
      OUT_WAKE_OEN:  return gpio_wake_n_oen;
      OUT_PREADY:    return apb_pready;
      default:       return apb_pslverr;
    endcase
  endfunction

  function automatic string out_name(input int sel);
    case (sel)
      OUT_INTERRUPT: return "interrupt";
      OUT_IN_PX:     return "in_px_state";
      OUT_IN_RESET:  return "in_reset_state";
      OUT_RESET_OEN: return "gpio_reset_n_oen";
      OUT_WAKE_OEN:  return "gpio_wake_n_oen";
      OUT_PREADY:    return "apb_pready";
      default:       return "apb_pslverr";
    endcase
  endfunction

  //------------------------------------------------------------
  // Stimulus tasks
  //------------------------------------------------------------
  task automatic apb_access(input logic [31:0] addr, input logic wr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    @(posedge apb_clk);
    apb_paddr   <= addr[`SLINK_ADDR_W-1:0];
    apb_pwrite  <= wr;
    apb_psel    <= 1'b1;
    apb_penable <= 1'b0;
    apb_pwdata  <= data;
    @(posedge apb_clk);
    apb_penable <= 1'b1;
    @(negedge apb_clk);
    check("apb_pready", 32'h1, 32'(apb_pready));
    rdata = apb_prdata;
    err   = apb_pslverr;
    // Write lands on this edge
    @(posedge apb_clk);
    apb_psel    <= 1'b0;
    apb_penable <= 1'b0;
    apb_pwrite  <= 1'b0;
  endtask

  task automatic pulse_inputs(input logic [31:0] mask);
    @(posedge apb_clk);
    ecc_corrected <= mask[0];
    ecc_corrupted <= mask[1];
    crc_corrupted <= mask[2];
    tx_sop        <= mask[3];
    p1_req        <= mask[4];
    p2_req        <= mask[5];
    p3_req        <= mask[6];
    @(posedge apb_clk);
    ecc_corrected <= 1'b0;
    ecc_corrupted <= 1'b0;
    crc_corrupted <= 1'b0;
    tx_sop        <= 1'b0;
    p1_req        <= 1'b0;
    p2_req        <= 1'b0;
    p3_req        <= 1'b0;
  endtask

  // Wait for the output to rise, then count cycles while high
  task automatic measure_high(input int sel, input int budget, input logic [31:0] exp);
    int waited;
    int width;
    waited = 0;
    width  = 0;
    @(negedge apb_clk);
    while (!out_value(sel) && waited < budget) begin
      waited++;
      @(negedge apb_clk);
    end
    if (!out_value(sel)) begin
      $display("%s did not rise within %0d cycles", out_name(sel), budget);
      n_errors++;
      test_errors++;
    end else begin
      // Reset pin drive follows the whole pulse
      while (out_value(sel) && width < budget) begin
        check(out_name(OUT_RESET_OEN), 32'h1, 32'(gpio_reset_n_oen));
        width++;
        @(negedge apb_clk);
      end
      check(out_name(OUT_RESET_OEN), 32'h0, 32'(gpio_reset_n_oen));
      check({out_name(sel), " high cycles"}, exp, width);
    end
  endtask

  task automatic apply_row(input int i);
    logic [31:0] rdata;
    logic        rerr;
    case (row_op[i])
      OP_WR: begin
        apb_access(row_addr[i], 1'b1, row_data[i], rdata, rerr);
        check("apb_pslverr", 32'h0, 32'(rerr));
      end
      OP_RD: begin
        apb_access(row_addr[i], 1'b0, 32'h0, rdata, rerr);
        check($sformatf("apb_prdata[0x%03h]", row_addr[i]), row_exp[i], rdata);
        check("apb_pslverr", 32'(row_data[i][0]), 32'(rerr));
      end
      OP_PULSE: pulse_inputs(row_data[i]);
      OP_PIN: begin
        @(posedge apb_clk);
        if (row_addr[i] == PIN_RESET) begin
          gpio_reset_n <= row_data[i][0];
        end else begin
          gpio_wake_n <= row_data[i][0];
        end
      end
      OP_WAIT: repeat (row_data[i]) @(posedge apb_clk);
      OP_CHK: begin
        @(negedge apb_clk);
        check(out_name(row_addr[i]), row_exp[i], 32'(out_value(row_addr[i])));
      end
      OP_MEAS: measure_high(row_addr[i], row_data[i], row_exp[i]);
      default: begin
        $display("row %0d holds an unknown operation %0d", i, row_op[i]);
        n_errors++;
        test_errors++;
      end
    endcase
  endtask

  //------------------------------------------------------------
  // Stimulus table
  //------------------------------------------------------------
  task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] exp, input int test);
    if (n_rows >= MAX_ROWS) begin
      $display("stimulus table is full, a row of test %0d was dropped", test);
      n_errors++;
    end else begin
      row_op[n_rows]   = op;
      row_addr[n_rows] = addr;
      row_data[n_rows] = data;
      row_exp[n_rows]  = exp;
      row_test[n_rows] = test;
      n_rows++;
    end
  endtask

  task automatic build_table();
    // Reset values, register fields, error decode
    for (int s = OUT_INTERRUPT; s <= OUT_PSLVERR; s++) begin
      add_row(OP_CHK, s, 0, 0, 1);
    end
    add_row(OP_RD, `SLINK_REG_TIMING, 0, 32'h0002_000A, 1);
    add_row(OP_WR, `SLINK_REG_CTRL, r_ctrl, 0, 1);
    add_row(OP_RD, `SLINK_REG_CTRL, 0, r_ctrl & 32'h3, 1);
    add_row(OP_WR, `SLINK_REG_INT_EN, r_int_en, 0, 1);
    add_row(OP_RD, `SLINK_REG_INT_EN, 0, r_int_en & 32'h3F, 1);
    add_row(OP_WR, `SLINK_REG_TIMING, r_timing, 0, 1);
    add_row(OP_RD, `SLINK_REG_TIMING, 0, r_timing & 32'h03FF_03FF, 1);
    add_row(OP_RD, `SLINK_REG_PX_CTRL, 0, 0, 1);
    add_row(OP_RD, 32'h018, 1, 0, 1);
    add_row(OP_RD, 32'h100, 1, 0, 1);
    add_row(OP_WR, `SLINK_REG_CTRL, 0, 0, 1);
    add_row(OP_WR, `SLINK_REG_INT_EN, 0, 0, 1);
    add_row(OP_WR, `SLINK_REG_TIMING, 32'h0002_000A, 0, 1);
    // Status and interrupt
    add_row(OP_PULSE, 0, PL_CRC, 0, 2);
    add_row(OP_PULSE, 0, PL_ECC_CORR, 0, 2);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h05, 2);
    add_row(OP_CHK, OUT_INTERRUPT, 0, 0, 2);
    add_row(OP_WR, `SLINK_REG_INT_EN, 32'h04, 0, 2);
    add_row(OP_CHK, OUT_INTERRUPT, 0, 1, 2);
    add_row(OP_WR, `SLINK_REG_INT_EN, 32'h05, 0, 2);
    add_row(OP_WR, `SLINK_REG_STATUS, 32'h04, 0, 2);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h01, 2);
    add_row(OP_CHK, OUT_INTERRUPT, 0, 1, 2);
    add_row(OP_WR, `SLINK_REG_INT_EN, 32'h04, 0, 2);
    add_row(OP_CHK, OUT_INTERRUPT, 0, 0, 2);
    add_row(OP_WR, `SLINK_REG_STATUS, 32'h3F, 0, 2);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h00, 2);
    // P-state entry and exit
    add_row(OP_PULSE, 0, PL_P2, 0, 3);
    add_row(OP_WAIT, 0, 2, 0, 3);
    add_row(OP_RD, `SLINK_REG_LINK_STATE, 0, 32'h00, 3);
    add_row(OP_WR, `SLINK_REG_CTRL, 32'h1, 0, 3);
    add_row(OP_PULSE, 0, PL_P1 | PL_P3, 0, 3);
    add_row(OP_WAIT, 0, 10, 0, 3);
    add_row(OP_RD, `SLINK_REG_LINK_STATE, 0, 32'h0E, 3);
    add_row(OP_CHK, OUT_IN_PX, 0, 1, 3);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h20, 3);
    add_row(OP_PULSE, 0, PL_TX_SOP, 0, 3);
    add_row(OP_CHK, OUT_WAKE_OEN, 0, 1, 3);
    add_row(OP_WAIT, 0, 18, 0, 3);
    add_row(OP_CHK, OUT_IN_PX, 0, 0, 3);
    add_row(OP_CHK, OUT_WAKE_OEN, 0, 0, 3);
    add_row(OP_RD, `SLINK_REG_LINK_STATE, 0, 32'h00, 3);
    // Hard reset of 4 x 3 cycles
    add_row(OP_WR, `SLINK_REG_TIMING, 32'h0003_0004, 0, 4);
    add_row(OP_WR, `SLINK_REG_PX_CTRL, 32'h08, 0, 4);
    add_row(OP_MEAS, OUT_IN_RESET, 20, 12, 4);
    add_row(OP_RD, `SLINK_REG_LINK_STATE, 0, 32'h00, 4);
    // Sideband pins and crc reset
    add_row(OP_WR, `SLINK_REG_STATUS, 32'h3F, 0, 5);
    add_row(OP_PULSE, 0, PL_P1, 0, 5);
    add_row(OP_WAIT, 0, 10, 0, 5);
    add_row(OP_CHK, OUT_IN_PX, 0, 1, 5);
    add_row(OP_WR, `SLINK_REG_STATUS, 32'h3F, 0, 5);
    add_row(OP_PIN, PIN_WAKE, 0, 0, 5);
    add_row(OP_WAIT, 0, 6, 0, 5);
    add_row(OP_CHK, OUT_WAKE_OEN, 0, 1, 5);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h10, 5);
    add_row(OP_PIN, PIN_WAKE, 1, 0, 5);
    add_row(OP_WAIT, 0, 20, 0, 5);
    add_row(OP_CHK, OUT_IN_PX, 0, 0, 5);
    add_row(OP_RD, `SLINK_REG_LINK_STATE, 0, 32'h00, 5);
    add_row(OP_WR, `SLINK_REG_STATUS, 32'h3F, 0, 5);
    add_row(OP_PIN, PIN_RESET, 0, 0, 5);
    add_row(OP_WAIT, 0, 5, 0, 5);
    add_row(OP_CHK, OUT_IN_RESET, 0, 1, 5);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h08, 5);
    add_row(OP_PIN, PIN_RESET, 1, 0, 5);
    add_row(OP_WAIT, 0, 15, 0, 5);
    add_row(OP_CHK, OUT_IN_RESET, 0, 0, 5);
    add_row(OP_WR, `SLINK_REG_STATUS, 32'h3F, 0, 5);
    add_row(OP_WR, `SLINK_REG_CTRL, 32'h3, 0, 5);
    add_row(OP_PULSE, 0, PL_CRC, 0, 5);
    add_row(OP_CHK, OUT_IN_RESET, 0, 1, 5);
    add_row(OP_CHK, OUT_RESET_OEN, 0, 1, 5);
    add_row(OP_RD, `SLINK_REG_STATUS, 0, 32'h04, 5);
    add_row(OP_WAIT, 0, 15, 0, 5);
    add_row(OP_CHK, OUT_IN_RESET, 0, 0, 5);
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial begin
    int wait_sum;
    apb_paddr     = '0;
    apb_pwrite    = 1'b0;
    apb_psel      = 1'b0;
    apb_penable   = 1'b0;
    apb_pwdata    = '0;
    ecc_corrected = 1'b0;
    ecc_corrupted = 1'b0;
    crc_corrupted = 1'b0;
    tx_sop        = 1'b0;
    p1_req        = 1'b0;
    p2_req        = 1'b0;
    p3_req        = 1'b0;
    gpio_reset_n  = 1'b1;
    gpio_wake_n   = 1'b1;
    arst_n        = 1'b0;
    n_rows        = 0;
    n_checks      = 0;
    n_errors      = 0;
    n_tests       = 0;
    test_errors   = 0;
    void'($urandom(45589));
    r_ctrl   = $urandom();
    r_int_en = $urandom();
    r_timing = $urandom();
    build_table();
    wait_sum = 0;
    for (int i = 0; i < n_rows; i++) begin
      if (row_op[i] == OP_WAIT || row_op[i] == OP_MEAS) begin
        wait_sum += row_data[i];
      end
    end
    limit = 2 * wait_sum + 200;
    repeat (5) @(posedge apb_clk);
    arst_n <= 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
      if (i == n_rows - 1 || row_test[i + 1] != row_test[i]) begin
        $display("test %0d finished with %0d mismatches", row_test[i], test_errors);
        n_tests++;
        test_errors = 0;
      end
    end
    $display("summary: %0d tests, %0d checks, %0d mismatches", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge apb_clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+hdl
hdl/slink_apb_pkg.sv
hdl/slink_link_pkg.sv
hdl/slink_sideband_sync.sv
hdl/slink_px_fsm.sv
hdl/slink_reset_timer.sv
hdl/slink_apb_regs.sv
hdl/slink_ctrl_top.sv
sim/tb_slink_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_slink_ctrl -f project.f -o tb_slink_ctrl

./obj_dir/tb_slink_ctrl | tee sim.log

if grep -q "all tests passed" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi
